/* Makefile */
VERILATOR ?= verilator
TOP ?= scpad_tb
FLIST ?= scpad.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Testbench passed
VFLAGS ?= --binary --timing --assert

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	./$(BIN) > $(LOG) 2>&1; cat $(LOG); grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/scpad_bank.sv */
module scpad_bank import scpad_pkg::*; (
    input logic clk,
    input logic n_rst,

    input logic rd_valid,
    input logic [addr_width-1:0] rd_addr,
    input logic rd_src,

    input logic wr_valid,
    input logic [addr_width-1:0] wr_addr,
    input scpad_word_u wr_data,
    input logic [lanes-1:0] wr_mask,

    output logic r_stall,

    output logic be_resp_valid,
    output scpad_word_u be_resp_data,
    output logic fe_resp_valid,
    output scpad_word_u fe_resp_data
);

    scpad_word_u mem [depth];

    // Read parked for one cycle behind a write
    logic hold_valid;
    logic [addr_width-1:0] hold_addr;
    logic hold_src;

    logic collide;
    logic rd_fire;
    logic [addr_width-1:0] rd_sel_addr;
    logic rd_sel_src;

    logic resp_valid;
    logic resp_src;
    scpad_word_u resp_data;

    // The write owns the port when both arrive together
    assign collide = rd_valid && wr_valid;

    // The head cannot grant during the hold cycle, so a parked read never
    // competes with a new one
    assign rd_fire = (rd_valid && !wr_valid) || hold_valid;
    assign rd_sel_addr = hold_valid ? hold_addr : rd_addr;
    assign rd_sel_src = hold_valid ? hold_src : rd_src;

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            for (int i = 0; i < lanes; i++) begin
                if (wr_mask[i]) begin
                    mem[wr_addr].lane[i] <= wr_data.lane[i];
                end
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            hold_valid <= 1'b0;
            resp_valid <= 1'b0;
            resp_src <= src_be;
        end else begin
            hold_valid <= collide;
            resp_valid <= rd_fire;
            if (rd_fire) begin
                resp_src <= rd_sel_src;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (collide) begin
            hold_addr <= rd_addr;
            hold_src <= rd_src;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            resp_data <= mem[rd_sel_addr];
        end
    end

    assign r_stall = hold_valid;

    // Steer the response by its tag
    assign be_resp_valid = resp_valid && (resp_src == src_be);
    assign fe_resp_valid = resp_valid && (resp_src == src_fe);
    assign be_resp_data = resp_data;
    assign fe_resp_data = resp_data;

endmodule

/* logic/scpad_head.sv */
module scpad_head import scpad_pkg::*; (
    input logic clk,
    input logic n_rst,

    input logic be_rd_valid,
    input logic [addr_width-1:0] be_rd_addr,
    input logic fe_rd_valid,
    input logic [addr_width-1:0] fe_rd_addr,

    input logic be_wr_valid,
    input logic [addr_width-1:0] be_wr_addr,
    input scpad_word_u be_wr_data,
    input logic [lanes-1:0] be_wr_mask,
    input logic fe_wr_valid,
    input logic [addr_width-1:0] fe_wr_addr,
    input scpad_word_u fe_wr_data,
    input logic [lanes-1:0] fe_wr_mask,

    input logic r_stall,

    output logic be_stall,
    output logic fe_stall,

    output logic rd_valid,
    output logic [addr_width-1:0] rd_addr,
    output logic rd_src,

    output logic wr_valid,
    output logic [addr_width-1:0] wr_addr,
    output scpad_word_u wr_data,
    output logic [lanes-1:0] wr_mask
);

    logic rd_busy;
    logic wr_busy;

    logic rd_grant_be, rd_grant_fe;
    logic wr_grant_be, wr_grant_fe;

    // A source is only accepted when its stall is low, so every grant
    // matches what the source sees on its stall line
    assign be_stall = r_stall
                   || (be_rd_valid && rd_busy)
                   || (be_wr_valid && wr_busy);

    assign fe_stall = r_stall
                   || (fe_rd_valid && (rd_busy || be_rd_valid))
                   || (fe_wr_valid && (wr_busy || be_wr_valid));

    assign rd_grant_be = be_rd_valid && !be_stall;
    assign rd_grant_fe = fe_rd_valid && !fe_stall;
    assign wr_grant_be = be_wr_valid && !be_stall;
    assign wr_grant_fe = fe_wr_valid && !fe_stall;

    // The busy flag is high for exactly the cycle after a grant and
    // is also the valid seen by the bank
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
        end else begin
            rd_busy <= rd_grant_be || rd_grant_fe;
            wr_busy <= wr_grant_be || wr_grant_fe;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_grant_be) begin
            rd_addr <= be_rd_addr;
            rd_src <= src_be;
        end else if (rd_grant_fe) begin
            rd_addr <= fe_rd_addr;
            rd_src <= src_fe;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_grant_be) begin
            wr_addr <= be_wr_addr;
            wr_data.raw <= be_wr_data.raw;
            wr_mask <= be_wr_mask;
        end else if (wr_grant_fe) begin
            wr_addr <= fe_wr_addr;
            wr_data.raw <= fe_wr_data.raw;
            wr_mask <= fe_wr_mask;
        end
    end

    assign rd_valid = rd_busy;
    assign wr_valid = wr_busy;

endmodule

/* logic/scpad_pkg.sv */
package scpad_pkg;

    // Bank geometry
    localparam int addr_width = 8;
    localparam int depth = 2 ** addr_width;

    // Word layout
    localparam int data_width = 32;
    localparam int lanes = 4;
    localparam int lane_width = data_width / lanes;

    // Read source tags carried alongside a granted read
    localparam logic src_be = 1'b0;
    localparam logic src_fe = 1'b1;

    // One data word, seen either whole or as byte lanes.
    // The bank merges writes per lane and everything else moves the raw word
    typedef union packed {
        logic [data_width-1:0] raw;
        logic [lanes-1:0][lane_width-1:0] lane;
    } scpad_word_u;

endpackage

/* logic/scpad_top.sv */
module scpad_top import scpad_pkg::*; (
    input logic clk,
    input logic n_rst,

    input logic be_rd_valid,
    input logic [addr_width-1:0] be_rd_addr,
    input logic be_wr_valid,
    input logic [addr_width-1:0] be_wr_addr,
    input scpad_word_u be_wr_data,
    input logic [lanes-1:0] be_wr_mask,

    input logic fe_rd_valid,
    input logic [addr_width-1:0] fe_rd_addr,
    input logic fe_wr_valid,
    input logic [addr_width-1:0] fe_wr_addr,
    input scpad_word_u fe_wr_data,
    input logic [lanes-1:0] fe_wr_mask,

    output logic be_stall,
    output logic fe_stall,

    output logic be_resp_valid,
    output scpad_word_u be_resp_data,
    output logic fe_resp_valid,
    output scpad_word_u fe_resp_data
);

    logic rd_valid;
    logic [addr_width-1:0] rd_addr;
    logic rd_src;
    logic wr_valid;
    logic [addr_width-1:0] wr_addr;
    scpad_word_u wr_data;
    logic [lanes-1:0] wr_mask;
    logic r_stall;

    scpad_head scpad_head_i (
        .clk(clk),
        .n_rst(n_rst),
        .be_rd_valid(be_rd_valid),
        .be_rd_addr(be_rd_addr),
        .fe_rd_valid(fe_rd_valid),
        .fe_rd_addr(fe_rd_addr),
        .be_wr_valid(be_wr_valid),
        .be_wr_addr(be_wr_addr),
        .be_wr_data(be_wr_data),
        .be_wr_mask(be_wr_mask),
        .fe_wr_valid(fe_wr_valid),
        .fe_wr_addr(fe_wr_addr),
        .fe_wr_data(fe_wr_data),
        .fe_wr_mask(fe_wr_mask),
        .r_stall(r_stall),
        .be_stall(be_stall),
        .fe_stall(fe_stall),
        .rd_valid(rd_valid),
        .rd_addr(rd_addr),
        .rd_src(rd_src),
        .wr_valid(wr_valid),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .wr_mask(wr_mask)
    );

    scpad_bank scpad_bank_i (
        .clk(clk),
        .n_rst(n_rst),
        .rd_valid(rd_valid),
        .rd_addr(rd_addr),
        .rd_src(rd_src),
        .wr_valid(wr_valid),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .wr_mask(wr_mask),
        .r_stall(r_stall),
        .be_resp_valid(be_resp_valid),
        .be_resp_data(be_resp_data),
        .fe_resp_valid(fe_resp_valid),
        .fe_resp_data(fe_resp_data)
    );

endmodule

/* scpad.f */
logic/scpad_pkg.sv
logic/scpad_head.sv
logic/scpad_bank.sv
logic/scpad_top.sv
tb/scpad_asserts.sv
tb/scpad_checker.sv
tb/scpad_tb.sv

/* tb/scpad_asserts.sv */
module scpad_asserts import scpad_pkg::*; (
    input logic clk,
    input logic n_rst,
    input logic be_rd_valid,
    input logic fe_rd_valid,
    input logic be_stall,
    input logic fe_stall,
    input logic rd_valid,
    input logic rd_src,
    input logic wr_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    // Each channel carries a granted request for a single cycle
    rd_single: assert property (@(posedge clk) disable iff (!n_rst) rd_valid |=> !rd_valid)
        else begin
            $error("head read valid held for two cycles");
            failures++;
        end
    wr_single: assert property (@(posedge clk) disable iff (!n_rst) wr_valid |=> !wr_valid)
        else begin
            $error("head write valid held for two cycles");
            failures++;
        end

    // The backend always wins a shared read channel
    fe_yields: assert property (@(posedge clk) disable iff (!n_rst)
        (be_rd_valid && fe_rd_valid && !be_stall)
            |-> fe_stall ##1 (rd_valid && rd_src == src_be))
        else begin
            $error("frontend not held off while backend also reads");
            failures++;
        end

    quiet_in_reset: assert property (@(posedge clk) !n_rst |-> (!rd_valid && !wr_valid))
        else begin
            $error("head valid high during reset");
            failures++;
        end

endmodule

/* tb/scpad_checker.sv */
module scpad_checker import scpad_pkg::*; (
    input logic clk,
    input logic n_rst,
    input logic be_rd_valid,
    input logic [addr_width-1:0] be_rd_addr,
    input logic be_wr_valid,
    input logic [addr_width-1:0] be_wr_addr,
    input logic [data_width-1:0] be_wr_data,
    input logic [lanes-1:0] be_wr_mask,
    input logic fe_rd_valid,
    input logic [addr_width-1:0] fe_rd_addr,
    input logic fe_wr_valid,
    input logic [addr_width-1:0] fe_wr_addr,
    input logic [data_width-1:0] fe_wr_data,
    input logic [lanes-1:0] fe_wr_mask,
    input logic be_stall,
    input logic fe_stall,
    input logic be_resp_valid,
    input logic [data_width-1:0] be_resp_data,
    input logic fe_resp_valid,
    input logic [data_width-1:0] fe_resp_data
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [data_width-1:0] ref_mem [depth];
    logic [data_width-1:0] be_exp [$];
    logic [data_width-1:0] fe_exp [$];
    string be_name [$];
    string fe_name [$];
    int checks = 0;
    int errors = 0;
    int outstanding = 0;

    task automatic merge_write(input logic [addr_width-1:0] a,
                               input logic [data_width-1:0] d,
                               input logic [lanes-1:0] m);
        for (int k = 0; k < lanes; k++) begin
            if (m[k]) begin
                ref_mem[a][k*lane_width +: lane_width] = d[k*lane_width +: lane_width];
            end
        end
    endtask

    task automatic compare(input string name, input logic [data_width-1:0] exp,
                           input logic [data_width-1:0] got);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %s: expected %08h, actual %08h", name, exp, got);
            errors++;
        end
    endtask

    // Writes land before reads accepted at the same edge, as in the bank
    always @(posedge clk) begin
        if (n_rst) begin
            if (be_wr_valid && !be_stall) merge_write(be_wr_addr, be_wr_data, be_wr_mask);
            if (fe_wr_valid && !fe_stall) merge_write(fe_wr_addr, fe_wr_data, fe_wr_mask);
            if (be_rd_valid && !be_stall) begin
                be_exp.push_back(ref_mem[be_rd_addr]);
                be_name.push_back(scpad_tb.test_name);
            end
            if (fe_rd_valid && !fe_stall) begin
                fe_exp.push_back(ref_mem[fe_rd_addr]);
                fe_name.push_back(scpad_tb.test_name);
            end
            if (be_resp_valid) begin
                if (be_exp.size() == 0) begin
                    $display("Backend got a read response with no read outstanding");
                    errors++;
                end else begin
                    compare(be_name.pop_front(), be_exp.pop_front(), be_resp_data);
                end
            end
            if (fe_resp_valid) begin
                if (fe_exp.size() == 0) begin
                    $display("Frontend got a read response with no read outstanding");
                    errors++;
                end else begin
                    compare(fe_name.pop_front(), fe_exp.pop_front(), fe_resp_data);
                end
            end
            outstanding = be_exp.size() + fe_exp.size();
        end
    end

endmodule

/* tb/scpad_input.txt */
# Columns: test op(R/W) source(B/F) addr(hex) data(hex) mask(hex)
# A lower-case op is issued in the same cycle as the line after it
full_rw W B 10 deadbeef f
full_rw R B 10 0 0
full_rw W F 20 cafef00d f
full_rw R F 20 0 0
full_rw R B 20 0 0
full_rw R F 10 0 0
partial W B 30 11223344 f
partial W F 30 aabbccdd 3
partial R B 30 0 0
partial W B 30 99000000 8
partial R F 30 0 0
contend W B 40 01010101 f
contend W F 41 02020202 f
contend r B 40 0 0
contend R F 41 0 0
contend w B 42 03030303 f
contend W F 43 04040404 f
contend R B 43 0 0
contend R F 42 0 0
collide W B 50 55555555 f
collide w B 50 66666666 f
collide R F 50 0 0
collide r F 50 0 0
collide W B 50 88888888 f
collide R B 50 0 0
rnd W F 60 a0a0a0a0 f
rnd W B 61 b1b1b1b1 f
rnd R F 10 0 0
rnd R B 60 0 0
rnd R F 61 0 0
rnd W B 62 c2c2c2c2 f
rnd W F 60 0000dd00 2
rnd R B 20 0 0
rnd R F 62 0 0
rnd R B 60 0 0
rnd R F 30 0 0

/* tb/scpad_tb.sv */
module scpad_tb import scpad_pkg::*; ;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk;
    logic n_rst;
    logic be_rd_valid, fe_rd_valid, be_wr_valid, fe_wr_valid;
    logic [addr_width-1:0] be_rd_addr, fe_rd_addr, be_wr_addr, fe_wr_addr;
    scpad_word_u be_wr_data, fe_wr_data, be_resp_data, fe_resp_data;
    logic [lanes-1:0] be_wr_mask, fe_wr_mask;
    logic be_stall, fe_stall, be_resp_valid, fe_resp_valid;

    string test_name;
    string name_q [$];
    string op_q [$];
    string src_q [$];
    int unsigned addr_q [$];
    int unsigned data_q [$];
    int unsigned mask_q [$];
    int cycles = 0;
    int limit = 0;

    scpad_top scpad_top_i (.*);

    scpad_checker checker_i (
        .clk(clk), .n_rst(n_rst),
        .be_rd_valid(be_rd_valid), .be_rd_addr(be_rd_addr),
        .be_wr_valid(be_wr_valid), .be_wr_addr(be_wr_addr),
        .be_wr_data(be_wr_data.raw), .be_wr_mask(be_wr_mask),
        .fe_rd_valid(fe_rd_valid), .fe_rd_addr(fe_rd_addr),
        .fe_wr_valid(fe_wr_valid), .fe_wr_addr(fe_wr_addr),
        .fe_wr_data(fe_wr_data.raw), .fe_wr_mask(fe_wr_mask),
        .be_stall(be_stall), .fe_stall(fe_stall),
        .be_resp_valid(be_resp_valid), .be_resp_data(be_resp_data.raw),
        .fe_resp_valid(fe_resp_valid), .fe_resp_data(fe_resp_data.raw)
    );

    bind scpad_head scpad_asserts scpad_asserts_i (
        .clk(clk), .n_rst(n_rst), .be_rd_valid(be_rd_valid), .fe_rd_valid(fe_rd_valid),
        .be_stall(be_stall), .fe_stall(fe_stall), .rd_valid(rd_valid), .rd_src(rd_src),
        .wr_valid(wr_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (limit > 0) begin
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: run did not finish within %0d cycles", limit);
                $display("Testbench failed");
                $finish;
            end
        end
    end

    function automatic bit is_read(int i);
        return op_q[i].toupper() == "R";
    endfunction

    function automatic bit stalled(int i);
        return (src_q[i] == "B") ? be_stall : fe_stall;
    endfunction

    task automatic drive(int i, bit on);
        if (src_q[i] == "B" && is_read(i)) begin
            be_rd_valid = on;
            be_rd_addr = addr_width'(addr_q[i]);
        end else if (src_q[i] == "B") begin
            be_wr_valid = on;
            be_wr_addr = addr_width'(addr_q[i]);
            be_wr_data.raw = data_q[i];
            be_wr_mask = lanes'(mask_q[i]);
        end else if (is_read(i)) begin
            fe_rd_valid = on;
            fe_rd_addr = addr_width'(addr_q[i]);
        end else begin
            fe_wr_valid = on;
            fe_wr_addr = addr_width'(addr_q[i]);
            fe_wr_data.raw = data_q[i];
            fe_wr_mask = lanes'(mask_q[i]);
        end
    endtask

    // Hold each request until an edge sees it with its stall low
    task automatic issue(int i, int j);
        bit p0, p1, a0, a1;
        p0 = 1'b1;
        p1 = (j >= 0);
        drive(i, 1'b1);
        if (p1) drive(j, 1'b1);
        while (p0 || p1) begin
            @(posedge clk);
            a0 = p0 && !stalled(i);
            a1 = p1 ? !stalled(j) : 1'b0;
            @(negedge clk);
            if (a0) begin
                drive(i, 1'b0);
                p0 = 1'b0;
            end
            if (a1) begin
                drive(j, 1'b0);
                p1 = 1'b0;
            end
        end
    endtask

    initial begin
        int fd, n, i, j, tests, chk0, err0;
        int unsigned a, d, m;
        string line, nm, op, sr;
        {be_rd_valid, fe_rd_valid, be_wr_valid, fe_wr_valid} = '0;
        {be_rd_addr, fe_rd_addr, be_wr_addr, fe_wr_addr} = '0;
        be_wr_data.raw = '0;
        fe_wr_data.raw = '0;
        be_wr_mask = '0;
        fe_wr_mask = '0;
        n_rst = 1'b0;
        tests = 0;
        void'($urandom(32'hff94));
        fd = $fopen("tb/scpad_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tb/scpad_input.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#"
                    && $sscanf(line, "%s %s %s %h %h %h", nm, op, sr, a, d, m) == 6) begin
                    name_q.push_back(nm);
                    op_q.push_back(op);
                    src_q.push_back(sr);
                    addr_q.push_back(a);
                    data_q.push_back(d);
                    mask_q.push_back(m);
                end
            end
            $fclose(fd);
        end
        n = name_q.size();
        limit = 6 * n + 50;
        repeat (10) @(negedge clk);
        n_rst = 1'b1;
        @(negedge clk);
        i = 0;
        chk0 = 0;
        err0 = 0;
        while (i < n) begin
            test_name = name_q[i];
            j = -1;
            if (op_q[i] != op_q[i].toupper()) begin
                // Explicit pair, issued from idle so both land on one edge
                j = i + 1;
                @(negedge clk);
            end else if (i + 1 < n && name_q[i + 1] == test_name && addr_q[i + 1] != addr_q[i]
                         && op_q[i + 1] == op_q[i + 1].toupper()
                         && (src_q[i + 1] != src_q[i] || is_read(i + 1) != is_read(i))
                         && $urandom % 4 == 0) begin
                j = i + 1;
            end else begin
                repeat ($urandom % 3) @(negedge clk);
            end
            issue(i, j);
            i = (j >= 0) ? j + 1 : i + 1;
            if (i == n || name_q[i] != test_name) begin
                while (checker_i.outstanding != 0) @(negedge clk);
                $display("Test %s done: %0d reads checked, %0d errors", test_name,
                         checker_i.checks - chk0, checker_i.errors - err0);
                chk0 = checker_i.checks;
                err0 = checker_i.errors;
                tests++;
            end
        end
        repeat (4) @(negedge clk);
        $display("Tests %0d, reads checked %0d, errors %0d, assertion failures %0d", tests,
                 checker_i.checks, checker_i.errors,
                 scpad_top_i.scpad_head_i.scpad_asserts_i.failures);
        if (n > 0 && checker_i.errors == 0 && checker_i.outstanding == 0
            && scpad_top_i.scpad_head_i.scpad_asserts_i.failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
